// ==== Bender.yml ====
package:
  name: mpeg_scrambler

sources:
  - include_dirs:
      - .
    files:
      - mpeg_pkg.sv
      - sync_fifo.sv
      - stream_splitter.sv
      - sign_scrambler.sv
      - stream_joiner.sv
      - mpeg_scrambler_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_mpeg_scrambler.sv

// ==== filelist.f ====
+incdir+.
mpeg_pkg.sv
sync_fifo.sv
stream_splitter.sv
sign_scrambler.sv
stream_joiner.sv
mpeg_scrambler_top.sv
tb_clock_gen.sv
tb_mpeg_scrambler.sv

// ==== mpeg_consts.svh ====
// widths, buffer depths, thresholds and the reset key for the MPEG scrambler; include where needed
`ifndef MPEG_CONSTS_SVH
`define MPEG_CONSTS_SVH

// stream byte and key widths
`define BYTE_W 8
`define KEY_W 16
`define KEY_DEFAULT 16'hACE1

// input buffer and the level that raises mpeg_prog_full
`define IN_DEPTH 32
`define IN_PROG_FULL 24

// video, misc and record buffers
`define PATH_DEPTH 16
`define PATH_AFULL 12

`define RUN_MAX 255
`define SLICE_MIN 8'h01
`define SLICE_MAX 8'hAF

`endif

// ==== mpeg_pkg.sv ====
// shared stream types and state encodings, imported by the scrambler RTL and testbench
`include "mpeg_consts.svh"

package mpeg_pkg;

	typedef logic [`BYTE_W-1:0] byte_t;
	typedef logic [`KEY_W-1:0] key_t;

	// which path a run of bytes took
	typedef enum logic {
		run_misc  = 1'b0,
		run_video = 1'b1
	} run_class_e;

	// 1 to RUN_MAX, zero never stored in a record
	typedef logic [7:0] run_len_t;

	// start code prefix scan, 00 00 01 then code byte
	typedef enum logic [1:0] {
		sc_idle,
		sc_zero,
		sc_zero_zero,
		sc_prefix
	} scan_state_e;

	typedef enum logic {
		join_idle,
		join_copy
	} join_state_e;

endpackage

// ==== mpeg_scrambler_top.sv ====
// top level of the MPEG stream scrambler, connecting the buffers, splitter, scrambler and joiner
`timescale 1ns/100ps
`include "mpeg_consts.svh"

module mpeg_scrambler_top (
	input  logic            clk,
	input  logic            rst_n,
	input  mpeg_pkg::byte_t mpeg_in,
	input  logic            mpeg_in_en,
	input  logic            stream_end,
	input  mpeg_pkg::key_t  key_in,
	input  logic            key_en,
	output mpeg_pkg::byte_t mpeg_out,
	output logic            mpeg_out_en,
	output logic            mpeg_prog_full
);

	import mpeg_pkg::*;

	localparam int REC_W = 1 + $bits(run_len_t);

	logic [`BYTE_W:0] in_fifo_dout;
	logic in_fifo_empty;

	byte_t split_data;
	logic split_in_rd;
	logic split_vid_wr;
	logic split_misc_wr;
	run_class_e split_rec_class;
	run_len_t split_rec_len;
	logic split_rec_wr;

	byte_t vid_fifo_dout;
	logic vid_fifo_empty;
	logic vid_fifo_afull;

	byte_t misc_fifo_dout;
	logic misc_fifo_empty;
	logic misc_fifo_afull;

	logic [REC_W-1:0] rec_fifo_dout;
	logic rec_fifo_empty;
	logic rec_fifo_afull;

	logic scr_vid_rd;
	byte_t scr_data;
	logic scr_empty;

	logic join_vid_rd;
	logic join_misc_rd;
	logic join_rec_rd;

	// end flag rides with its byte
	sync_fifo #(
		.WIDTH(`BYTE_W + 1),
		.DEPTH(`IN_DEPTH),
		.AFULL(`IN_PROG_FULL)
	) in_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.din({stream_end, mpeg_in}),
		.wr(mpeg_in_en),
		.dout(in_fifo_dout),
		.rd(split_in_rd),
		.empty(in_fifo_empty),
		.afull(mpeg_prog_full)
	);

	stream_splitter splitter (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(in_fifo_dout[`BYTE_W-1:0]),
		.in_end(in_fifo_dout[`BYTE_W]),
		.in_empty(in_fifo_empty),
		.in_rd(split_in_rd),
		.vid_afull(vid_fifo_afull),
		.misc_afull(misc_fifo_afull),
		.rec_afull(rec_fifo_afull),
		.out_data(split_data),
		.vid_wr(split_vid_wr),
		.misc_wr(split_misc_wr),
		.rec_class(split_rec_class),
		.rec_len(split_rec_len),
		.rec_wr(split_rec_wr)
	);

	sync_fifo #(
		.WIDTH(`BYTE_W),
		.DEPTH(`PATH_DEPTH),
		.AFULL(`PATH_AFULL)
	) vid_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.din(split_data),
		.wr(split_vid_wr),
		.dout(vid_fifo_dout),
		.rd(scr_vid_rd),
		.empty(vid_fifo_empty),
		.afull(vid_fifo_afull)
	);

	sync_fifo #(
		.WIDTH(`BYTE_W),
		.DEPTH(`PATH_DEPTH),
		.AFULL(`PATH_AFULL)
	) misc_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.din(split_data),
		.wr(split_misc_wr),
		.dout(misc_fifo_dout),
		.rd(join_misc_rd),
		.empty(misc_fifo_empty),
		.afull(misc_fifo_afull)
	);

	sync_fifo #(
		.WIDTH(REC_W),
		.DEPTH(`PATH_DEPTH),
		.AFULL(`PATH_AFULL)
	) rec_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.din({split_rec_class, split_rec_len}),
		.wr(split_rec_wr),
		.dout(rec_fifo_dout),
		.rd(join_rec_rd),
		.empty(rec_fifo_empty),
		.afull(rec_fifo_afull)
	);

	sign_scrambler scrambler (
		.clk(clk),
		.rst_n(rst_n),
		.key_in(key_in),
		.key_en(key_en),
		.in_data(vid_fifo_dout),
		.in_empty(vid_fifo_empty),
		.in_rd(scr_vid_rd),
		.vid_data(scr_data),
		.vid_empty(scr_empty),
		.vid_rd(join_vid_rd)
	);

	stream_joiner joiner (
		.clk(clk),
		.rst_n(rst_n),
		.rec_class(run_class_e'(rec_fifo_dout[REC_W-1])),
		.rec_len(rec_fifo_dout[REC_W-2:0]),
		.rec_empty(rec_fifo_empty),
		.rec_rd(join_rec_rd),
		.vid_data(scr_data),
		.vid_empty(scr_empty),
		.vid_rd(join_vid_rd),
		.misc_data(misc_fifo_dout),
		.misc_empty(misc_fifo_empty),
		.misc_rd(join_misc_rd),
		.mpeg_out(mpeg_out),
		.mpeg_out_en(mpeg_out_en)
	);

endmodule

// ==== sign_scrambler.sv ====
// flips bit 0 of video bytes by an LFSR keystream and presents them FIFO-style to the joiner
`timescale 1ns/100ps
`include "mpeg_consts.svh"

module sign_scrambler (
	input  logic            clk,
	input  logic            rst_n,
	input  mpeg_pkg::key_t  key_in,
	input  logic            key_en,
	input  mpeg_pkg::byte_t in_data,
	input  logic            in_empty,
	output logic            in_rd,
	output mpeg_pkg::byte_t vid_data,
	output logic            vid_empty,
	input  logic            vid_rd
);

	import mpeg_pkg::*;

	key_t lfsr;
	logic vid_valid;
	logic key_bit;
	logic feedback;
	logic carries_sign;
	byte_t scrambled;

	// refill when the register is free or is being taken this cycle
	assign in_rd = ~in_empty & (~vid_valid | vid_rd);
	assign vid_empty = ~vid_valid;

	// fibonacci taps 16 14 13 11
	assign key_bit = lfsr[15];
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// 00 and 01 stay intact so start code prefixes survive
	assign carries_sign = (in_data >= 8'd2);
	assign scrambled = {in_data[7:1], in_data[0] ^ (carries_sign & key_bit)};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr <= `KEY_DEFAULT;
			vid_valid <= 1'b0;
		end else begin
			if (key_en)
				lfsr <= (key_in == '0) ? key_t'(`KEY_DEFAULT) : key_in;
			else if (in_rd & carries_sign)
				lfsr <= {lfsr[14:0], feedback};
			if (in_rd)
				vid_valid <= 1'b1;
			else if (vid_rd)
				vid_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_rd)
			vid_data <= scrambled;
	end

endmodule

// ==== stream_joiner.sv ====
// merges the video and misc paths back into stream order by replaying the run records
`timescale 1ns/100ps

module stream_joiner (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mpeg_pkg::run_class_e rec_class,
	input  mpeg_pkg::run_len_t   rec_len,
	input  logic                 rec_empty,
	output logic                 rec_rd,
	input  mpeg_pkg::byte_t      vid_data,
	input  logic                 vid_empty,
	output logic                 vid_rd,
	input  mpeg_pkg::byte_t      misc_data,
	input  logic                 misc_empty,
	output logic                 misc_rd,
	output mpeg_pkg::byte_t      mpeg_out,
	output logic                 mpeg_out_en
);

	import mpeg_pkg::*;

	join_state_e state;
	run_class_e cur_class;
	run_len_t remaining;
	logic src_empty;
	logic take;

	assign rec_rd = (state == join_idle) & ~rec_empty;

	assign src_empty = (cur_class == run_video) ? vid_empty : misc_empty;
	assign take = (state == join_copy) & ~src_empty;
	assign vid_rd = take & (cur_class == run_video);
	assign misc_rd = take & (cur_class == run_misc);

	assign mpeg_out = (cur_class == run_video) ? vid_data : misc_data;
	assign mpeg_out_en = take;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= join_idle;
			cur_class <= run_misc;
			remaining <= '0;
		end else begin
			case (state)
				join_idle: begin
					if (rec_rd) begin
						cur_class <= rec_class;
						remaining <= rec_len;
						state <= join_copy;
					end
				end
				join_copy: begin
					if (take) begin
						remaining <= remaining - 1'b1;
						// last byte of the run
						if (remaining == 8'd1)
							state <= join_idle;
					end
				end
				default: state <= join_idle;
			endcase
		end
	end

endmodule

// ==== stream_splitter.sv ====
// start code scanner that routes stream bytes to the video or misc path and logs runs
`timescale 1ns/100ps
`include "mpeg_consts.svh"

module stream_splitter (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mpeg_pkg::byte_t      in_data,
	input  logic                 in_end,
	input  logic                 in_empty,
	output logic                 in_rd,
	input  logic                 vid_afull,
	input  logic                 misc_afull,
	input  logic                 rec_afull,
	output mpeg_pkg::byte_t      out_data,
	output logic                 vid_wr,
	output logic                 misc_wr,
	output mpeg_pkg::run_class_e rec_class,
	output mpeg_pkg::run_len_t   rec_len,
	output logic                 rec_wr
);

	import mpeg_pkg::*;

	scan_state_e state;
	scan_state_e state_nx;
	run_class_e section;
	run_class_e section_nx;
	run_len_t run_len;
	run_len_t run_len_inc;
	logic cur_afull;
	logic run_done;
	logic flush;

	assign in_rd = ~in_empty & ~vid_afull & ~misc_afull & ~rec_afull;
	assign run_len_inc = run_len + 1'b1;

	// pending run is flushed when its own path fills, else the joiner could never drain it
	assign cur_afull = (section == run_video) ? vid_afull : misc_afull;
	assign flush = cur_afull & ~rec_afull & (run_len != '0);

	always_comb begin
		state_nx = state;
		section_nx = section;
		case (state)
			sc_idle: begin
				if (in_data == 8'h00)
					state_nx = sc_zero;
			end
			sc_zero: begin
				state_nx = (in_data == 8'h00) ? sc_zero_zero : sc_idle;
			end
			sc_zero_zero: begin
				if (in_data == 8'h01)
					state_nx = sc_prefix;
				else if (in_data != 8'h00)
					state_nx = sc_idle;
			end
			sc_prefix: begin
				// code byte picks the section of what follows
				state_nx = sc_idle;
				if (in_data >= `SLICE_MIN && in_data <= `SLICE_MAX)
					section_nx = run_video;
				else
					section_nx = run_misc;
			end
			default: state_nx = sc_idle;
		endcase
		if (in_end) begin
			state_nx = sc_idle;
			section_nx = run_misc;
		end
	end

	// run closes at the byte before a class change, so one record per byte at most
	assign run_done = in_end | (run_len_inc == `RUN_MAX) | (section_nx != section);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= sc_idle;
			section <= run_misc;
			run_len <= '0;
			vid_wr <= 1'b0;
			misc_wr <= 1'b0;
			rec_wr <= 1'b0;
		end else begin
			vid_wr <= in_rd & (section == run_video);
			misc_wr <= in_rd & (section == run_misc);
			rec_wr <= (in_rd & run_done) | flush;
			if (in_rd) begin
				state <= state_nx;
				section <= section_nx;
				run_len <= run_done ? '0 : run_len_inc;
			end else if (flush) begin
				run_len <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_rd)
			out_data <= in_data;
		if (in_rd) begin
			rec_class <= section;
			rec_len <= run_len_inc;
		end else if (flush) begin
			rec_class <= section;
			rec_len <= run_len;
		end
	end

endmodule

// ==== sync_fifo.sv ====
// single-clock FIFO with first-word fall-through output, empty, almost-full and fill count
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	parameter int AFULL = 12
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] din,
	input  logic             wr,
	output logic [WIDTH-1:0] dout,
	input  logic             rd,
	output logic             empty,
	output logic             afull
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_wr;
	logic do_rd;

	// a write into a full buffer is dropped
	assign do_wr = wr & (int'(count) < DEPTH);
	assign do_rd = rd & ~empty;

	assign empty = (count == '0);
	assign afull = (int'(count) >= AFULL);
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr & ~do_rd)
				count <= count + 1'b1;
			else if (do_rd & ~do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

endmodule

// ==== tb_clock_gen.sv ====
// free-running clock source for the scrambler testbench, instantiated once by the testbench top
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter real PERIOD = 10.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

// ==== tb_mpeg_scrambler.sv ====
// testbench for the MPEG scrambler top level, random streams checked against a reference model
`timescale 1ns/100ps
`include "mpeg_consts.svh"

module tb_mpeg_scrambler;

	import mpeg_pkg::*;

	logic clk;
	logic rst_n;
	byte_t mpeg_in;
	logic mpeg_in_en;
	logic stream_end;
	key_t key_in;
	logic key_en;
	byte_t mpeg_out;
	logic mpeg_out_en;
	logic mpeg_prog_full;

	integer seed;
	int max_gap;
	int bytes_sent = 0;
	int cycles;
	int stream_got;
	logic saw_full;

	byte_t pkt[$];
	byte_t exp_q[$];
	logic exp_end_q[$];
	int len_q[$];

	// reference model state
	scan_state_e m_scan;
	run_class_e m_section;
	key_t m_lfsr;

	tb_clock_gen #(.PERIOD(10.0)) clock_gen (.clk(clk));

	mpeg_scrambler_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.mpeg_in(mpeg_in),
		.mpeg_in_en(mpeg_in_en),
		.stream_end(stream_end),
		.key_in(key_in),
		.key_en(key_en),
		.mpeg_out(mpeg_out),
		.mpeg_out_en(mpeg_out_en),
		.mpeg_prog_full(mpeg_prog_full)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail at time %0t: mpeg_out got %02h expected %02h",
				$time, got, exp));
	endtask

	task automatic check_count(input run_len_t got, input run_len_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail at time %0t: mpeg_out_en count got %0d expected %0d",
				$time, got, exp));
	endtask

	// expected output for one sent byte, then advance the start code scan
	task automatic model_byte(input byte_t b, input logic last);
		byte_t o;
		o = b;
		if (m_section == run_video && b >= 8'd2) begin
			o[0] = b[0] ^ m_lfsr[15];
			m_lfsr = {m_lfsr[14:0], m_lfsr[15] ^ m_lfsr[13] ^ m_lfsr[12] ^ m_lfsr[10]};
		end
		exp_q.push_back(o);
		exp_end_q.push_back(last);
		case (m_scan)
			sc_idle: m_scan = (b == 8'h00) ? sc_zero : sc_idle;
			sc_zero: m_scan = (b == 8'h00) ? sc_zero_zero : sc_idle;
			sc_zero_zero: begin
				if (b == 8'h01)
					m_scan = sc_prefix;
				else if (b != 8'h00)
					m_scan = sc_idle;
			end
			default: begin
				m_scan = sc_idle;
				m_section = (b >= `SLICE_MIN && b <= `SLICE_MAX) ? run_video : run_misc;
			end
		endcase
		if (last) begin
			m_scan = sc_idle;
			m_section = run_misc;
		end
	endtask

	function automatic byte_t payload_byte(input logic plain);
		int r;
		r = {$random(seed)} % 8;
		if (!plain && r == 0)
			return 8'h00;
		if (!plain && r == 1)
			return 8'h01;
		return byte_t'(2 + {$random(seed)} % 254);
	endfunction

	function automatic byte_t slice_code();
		return byte_t'(`SLICE_MIN + {$random(seed)} % (`SLICE_MAX - `SLICE_MIN + 1));
	endfunction

	function automatic byte_t misc_code();
		return byte_t'(8'hB0 + {$random(seed)} % 80);
	endfunction

	task automatic add_code(input byte_t code);
		pkt.push_back(8'h00);
		pkt.push_back(8'h00);
		pkt.push_back(8'h01);
		pkt.push_back(code);
	endtask

	task automatic add_payload(input int n, input logic plain);
		for (int i = 0; i < n; i++)
			pkt.push_back(payload_byte(plain));
	endtask

	task automatic send_byte(input byte_t b, input logic last);
		int gap;
		gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
		repeat (gap) begin
			@(posedge clk);
			mpeg_in_en <= 1'b0;
			stream_end <= 1'b0;
		end
		// at most one write in flight past the threshold
		@(negedge clk);
		while (mpeg_prog_full) begin
			@(posedge clk);
			mpeg_in_en <= 1'b0;
			stream_end <= 1'b0;
			@(negedge clk);
		end
		@(posedge clk);
		mpeg_in <= b;
		mpeg_in_en <= 1'b1;
		stream_end <= last;
		model_byte(b, last);
		bytes_sent++;
	endtask

	task automatic send_packet();
		len_q.push_back(pkt.size());
		for (int i = 0; i < pkt.size(); i++)
			send_byte(pkt[i], i == pkt.size() - 1);
		pkt.delete();
		@(posedge clk);
		mpeg_in_en <= 1'b0;
		stream_end <= 1'b0;
	endtask

	task automatic wait_drained();
		int limit;
		limit = 60 * exp_q.size() + 100;
		while (exp_q.size() != 0 && limit > 0) begin
			@(posedge clk);
			limit--;
		end
		// a stream cut short comes out with too few bytes
		if (exp_q.size() != 0) begin
			check_count(run_len_t'(stream_got), run_len_t'(len_q[0]));
			abort_run("the output stopped before the stream was complete");
		end
		repeat (4) @(posedge clk);
	endtask

	// keys only change with no stream in flight
	task automatic load_key(input key_t k);
		wait_drained();
		@(posedge clk);
		key_in <= k;
		key_en <= 1'b1;
		@(posedge clk);
		key_en <= 1'b0;
		m_lfsr = (k == '0) ? key_t'(`KEY_DEFAULT) : k;
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (mpeg_prog_full)
				saw_full = 1'b1;
			if (mpeg_out_en) begin
				if (exp_q.size() == 0) begin
					abort_run("mpeg_out_en went high with no byte left to expect");
				end else begin
					check_byte(mpeg_out, exp_q.pop_front());
					stream_got++;
					if (exp_end_q.pop_front()) begin
						void'(len_q.pop_front());
						stream_got = 0;
					end
				end
			end
		end
	end

	// 60 cycles per byte sent plus 1000
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > 60 * bytes_sent + 1000)
				abort_run("timeout: the DUT stopped producing the expected bytes");
		end
	end

	initial begin
		seed = 50;
		max_gap = 3;
		saw_full = 1'b0;
		stream_got = 0;
		rst_n = 1'b0;
		mpeg_in = '0;
		mpeg_in_en = 1'b0;
		stream_end = 1'b0;
		key_in = '0;
		key_en = 1'b0;
		m_scan = sc_idle;
		m_section = run_misc;
		m_lfsr = `KEY_DEFAULT;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// no slice codes at all
		add_code(8'hB3);
		add_payload(40, 1'b1);
		add_code(8'hB8);
		add_payload(30, 1'b1);
		add_code(8'h00);
		add_payload(25, 1'b1);
		send_packet();

		// slice sections with 00 and 01 mixed in
		add_code(8'hB3);
		add_payload(10, 1'b1);
		add_code(8'h01);
		add_payload(60, 1'b0);
		add_code(8'hAF);
		add_payload(40, 1'b0);
		add_code(8'hB5);
		add_payload(10, 1'b1);
		send_packet();

		// mixed sections, each stream with a slice run past RUN_MAX
		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < 6; k++) begin
				if ({$random(seed)} % 2)
					add_code(slice_code());
				else
					add_code(misc_code());
				add_payload(1 + {$random(seed)} % 40, 1'b0);
			end
			add_code(slice_code());
			add_payload(300 + 20 * s, 1'b0);
			send_packet();
		end

		// stream ends inside a slice, next one starts as misc
		add_code(8'h05);
		add_payload(20, 1'b0);
		send_packet();
		add_payload(20, 1'b1);
		add_code(8'hB2);
		add_payload(10, 1'b1);
		send_packet();

		load_key(16'h1234);
		add_code(8'h10);
		add_payload(80, 1'b0);
		send_packet();
		load_key(16'h0000);
		add_code(8'h20);
		add_payload(80, 1'b0);
		send_packet();

		// short runs back to back, the joiner falls behind
		max_gap = 0;
		saw_full = 1'b0;
		for (int k = 0; k < 80; k++) begin
			add_code(slice_code());
			add_payload(2, 1'b1);
			add_code(misc_code());
			add_payload(1, 1'b1);
		end
		send_packet();
		wait_drained();

		if (!saw_full) begin
			abort_run("mpeg_prog_full never rose during the burst test");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule
